/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_la_core
FLIST = la_core.f
BUILD = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* capture_ctrl.sv */
// sample ring with post-trigger count and newest-first readout
// read count capped at DEPTH, readout cannot be stalled
module capture_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_in,
  input  logic                          clr_i,
  input  logic                          arm_i,
  input  logic                          trig_i,
  input  logic                          smpl_stb_i,
  input  la_trig_pkg::smpl_t            smpls_i,
  input  logic [la_trig_pkg::CNT_W-1:0] delay_cnt_i,
  input  logic [la_trig_pkg::CNT_W-1:0] read_cnt_i,
  output logic                          armed_o,
  output logic                          dout_vld_o,
  output la_trig_pkg::smpl_t            dout_o
);
  import la_trig_pkg::*;

  smpl_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, wr_ptr_d;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] post_q;    // post-trigger samples still to store
  logic [CNT_W-1:0] rd_left_q; // words still to fetch
  logic [CNT_W-1:0] rd_cap;
  cap_state_e       state_q;
  logic             we, go_read, issue;
  logic             vld_q;
  smpl_t            dout_q;

  assign we       = smpl_stb_i && (state_q == FILL || state_q == POST);
  assign wr_ptr_d = wr_ptr_q + PTR_W'(we);
  assign rd_cap   = (read_cnt_i > CNT_W'(DEPTH)) ? CNT_W'(DEPTH) : read_cnt_i;
  assign issue    = (state_q == READ) && (rd_left_q != '0);

  // zero delay skips POST, otherwise the last post strobe ends it
  assign go_read = (state_q == FILL && trig_i && delay_cnt_i == '0) ||
                   (state_q == POST && smpl_stb_i && post_q == CNT_W'(1));

  always_ff @(posedge clk_i) begin
    if (we) mem[wr_ptr_q] <= smpls_i;
    if (issue) dout_q <= mem[rd_ptr_q]; // read register, word out 1 cycle after issue
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in || clr_i) begin
      state_q   <= STOP;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      post_q    <= '0;
      rd_left_q <= '0;
      vld_q     <= 1'b0;
    end else begin
      wr_ptr_q <= wr_ptr_d;
      vld_q    <= issue;
      if (go_read) begin
        state_q   <= READ;
        rd_ptr_q  <= wr_ptr_d - PTR_W'(1); // newest stored sample
        rd_left_q <= rd_cap;
      end else begin
        case (state_q)
          STOP: if (arm_i) state_q <= FILL;
          FILL: begin
            if (trig_i) begin
              state_q <= POST;
              post_q  <= delay_cnt_i;
            end
          end
          POST: if (smpl_stb_i) post_q <= post_q - CNT_W'(1);
          READ: begin
            if (issue) begin
              rd_ptr_q  <= rd_ptr_q - PTR_W'(1); // walk backwards
              rd_left_q <= rd_left_q - CNT_W'(1);
            end
            if (!issue && !vld_q) state_q <= STOP; // last word has left
          end
          default: state_q <= STOP;
        endcase
      end
    end
  end

  assign armed_o    = (state_q == FILL) || (state_q == POST);
  assign dout_vld_o = vld_q;
  assign dout_o     = dout_q;

  // output only while streaming, READ is held until the pipeline drains
  a_vld_in_read: assert property (@(posedge clk_i) disable iff (!rst_in)
    dout_vld_o |-> state_q == READ);

endmodule : capture_ctrl

/* la_cmd_pkg.sv */
// SUMP command protocol as seen after byte assembly, one opcode plus one data word
// only the subset used by the trigger/capture core is listed, other opcodes get dropped
package la_cmd_pkg;

  localparam int CMD_W       = 32; // command data word
  localparam int STG_SEL_LSB = 2;  // stage number sits in op[3:2]
  localparam int STG_SEL_W   = 2;

  // stage opcodes step by 4 per stage: 0xC0 + 4*stg + kind
  typedef enum logic [7:0] {
    OP_RESET      = 8'h00,
    OP_ARM        = 8'h01,
    OP_SET_COUNTS = 8'h81, // [31:16] delay, [15:0] read count, plain samples
    OP_SET_MASK0  = 8'hC0,
    OP_SET_VAL0   = 8'hC1,
    OP_SET_CFG0   = 8'hC2,
    OP_SET_MASK1  = 8'hC4,
    OP_SET_VAL1   = 8'hC5,
    OP_SET_CFG1   = 8'hC6,
    OP_SET_MASK2  = 8'hC8,
    OP_SET_VAL2   = 8'hC9,
    OP_SET_CFG2   = 8'hCA,
    OP_SET_MASK3  = 8'hCC,
    OP_SET_VAL3   = 8'hCD,
    OP_SET_CFG3   = 8'hCE
  } sump_op_e;

endpackage : la_cmd_pkg

/* la_core.f */
la_cmd_pkg.sv
la_trig_pkg.sv
trig_cfg_if.sv
sump_cmd_dec.sv
trig_stage.sv
capture_ctrl.sv
la_core.sv
tb_la_core.sv

/* la_core.sv */
// trigger and capture core of a 32 channel SUMP analyzer, UART side not included
// trig_o goes high 1 cycle after the run pulse of any active stage
module la_core (
  input  logic                         clk_i,
  input  logic                         rst_in,
  input  logic                         cmd_stb_i,
  input  logic [7:0]                   cmd_op_i,
  input  logic [la_cmd_pkg::CMD_W-1:0] cmd_data_i,
  input  logic                         smpl_stb_i,
  input  la_trig_pkg::smpl_t           smpls_i,
  output logic                         trig_o,
  output logic                         armed_o,
  output logic                         dout_vld_o,
  output la_trig_pkg::smpl_t           dout_o
);
  import la_cmd_pkg::*;
  import la_trig_pkg::*;

  logic             core_clr;
  logic             arm;
  logic [CNT_W-1:0] delay_cnt, read_cnt;
  logic [N_STG-1:0] run; // per stage, already gated by active bit
  logic             trig_q;

  trig_cfg_if cfg_if ();

  sump_cmd_dec u_dec (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .cmd_stb_i   (cmd_stb_i),
    .cmd_op_i    (sump_op_e'(cmd_op_i)),
    .cmd_data_i  (cmd_data_i),
    .cfg         (cfg_if),
    .core_clr_o  (core_clr),
    .arm_o       (arm),
    .delay_cnt_o (delay_cnt),
    .read_cnt_o  (read_cnt)
  );

  for (genvar g = 0; g < N_STG; g++) begin : g_stg
    trig_stage #(.STG(g)) u_stg (
      .clk_i      (clk_i),
      .rst_in     (rst_in),
      .clr_i      (core_clr),
      .cfg        (cfg_if),
      .smpl_stb_i (smpl_stb_i),
      .smpls_i    (smpls_i),
      .run_o      (run[g])
    );
  end

  // stages all sit at level 0, any one of them starts the capture
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      trig_q <= 1'b0;
    end else begin
      trig_q <= |run;
    end
  end

  capture_ctrl u_cap (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .clr_i       (core_clr),
    .arm_i       (arm),
    .trig_i      (trig_q),
    .smpl_stb_i  (smpl_stb_i),
    .smpls_i     (smpls_i),
    .delay_cnt_i (delay_cnt),
    .read_cnt_i  (read_cnt),
    .armed_o     (armed_o),
    .dout_vld_o  (dout_vld_o),
    .dout_o      (dout_o)
  );

  assign trig_o = trig_q;

endmodule : la_core

/* la_stim.txt */
# C op data = command, S smpl = strobed sample, I n = idle cycles, A lvl = armed_o level
# T = trig_o due at next cycle, R word = next readout word, all values hex
A 0
C C0 000000FF
C C1 000000A5
C C2 08000000
C 01 00000000
I 1
S 123456F0
S FFFFFFA5
S 00000000
T
I 2
C C4 000000FF
C C5 0000003C
C C6 00000000
C 01 00000000
I 1
S 0000003C
S 00000000
I 2
C C6 08000000
C 01 00000000
I 1
S 0000003C
S 00000000
T
I 2
C C8 0000000F
C C9 0000000B
C CA 08000000
C 01 00000000
I 1
S 00000000
S 00000020
S 00000000
S 00000020
S 00000020
S 00000000
I 2
C CA 0C500000
C 01 00000000
I 1
S 00000000
S 00000020
S 00000000
S 00000020
S 00000020
S 00000000
T
I 2
C 81 00030006
C 01 00000000
I 2
A 1
S 10000001
S 20000002
S 30000003
S 40000004
S DEAD00A5
S 50000005
T
I 1
S 60000006
S 70000007
S 80000008
R 80000008
R 70000007
R 60000006
R 50000005
R DEAD00A5
R 40000004
I 10
C 81 00050004
C 01 00000000
I 2
A 1
S 11111101
S 222200A5
S 33333302
T
I 1
S 44444403
S 55555504
C 00 00000000
I 2
A 0
S 66666605
I 8
C 01 00000000
I 2
A 1

/* la_trig_pkg.sv */
// trigger and capture types for the 32 channel core
// config word bits follow the SUMP byte layout, channel field is fixed at 5 bits
package la_trig_pkg;

  localparam int CHLS  = 32;            // sampled channels
  localparam int N_STG = 4;             // parallel trigger stages, all level 0
  localparam int DEPTH = 64;            // sample ring entries
  localparam int PTR_W = $clog2(DEPTH); // ring address
  localparam int CNT_W = 16;            // delay and read counts
  localparam int CHL_W = $clog2(CHLS);  // serial channel select

  // stage config word
  localparam int CFG_ACT    = 27; // stage may start a capture
  localparam int CFG_SER    = 26; // serial compare mode
  localparam int CFG_CHL_B4 = 24; // channel msb
  localparam int CFG_CHL_HI = 23; // channel bits 3..0
  localparam int CFG_CHL_LO = 20;

  typedef logic [CHLS-1:0] smpl_t;

  // per stage trigger state
  typedef enum logic [1:0] {
    IDLE,
    ARMD,
    MTCHD
  } stg_state_e;

  // capture controller state
  typedef enum logic [1:0] {
    STOP, // ring frozen, waiting for arm
    FILL, // pre-trigger recording
    POST, // counting post-trigger samples
    READ  // streaming out newest first
  } cap_state_e;

endpackage : la_trig_pkg

/* sump_cmd_dec.sv */
// takes one assembled SUMP command per strobe and answers 1 cycle later
// opcodes outside la_cmd_pkg::sump_op_e are silently ignored
module sump_cmd_dec (
  input  logic                           clk_i,
  input  logic                           rst_in,
  input  logic                           cmd_stb_i,
  input  la_cmd_pkg::sump_op_e           cmd_op_i,
  input  logic [la_cmd_pkg::CMD_W-1:0]   cmd_data_i,
  trig_cfg_if.dec                        cfg,
  output logic                           core_clr_o,
  output logic                           arm_o,
  output logic [la_trig_pkg::CNT_W-1:0]  delay_cnt_o,
  output logic [la_trig_pkg::CNT_W-1:0]  read_cnt_o
);
  import la_cmd_pkg::*;
  import la_trig_pkg::*;

  logic [STG_SEL_W-1:0] stg_idx;
  logic [N_STG-1:0]     mask_d, val_d, cfg_d;
  logic                 clr_d, arm_d, cnt_ld;
  logic [CMD_W-1:0]     data_q;
  logic [N_STG-1:0]     mask_q, val_q, cfg_q;
  logic                 clr_q, arm_q;
  logic [CNT_W-1:0]     delay_q, read_q;

  assign stg_idx = cmd_op_i[STG_SEL_LSB +: STG_SEL_W]; // meaningful for stage ops only

  always_comb begin
    mask_d = '0;
    val_d  = '0;
    cfg_d  = '0;
    clr_d  = 1'b0;
    arm_d  = 1'b0;
    cnt_ld = 1'b0;
    if (cmd_stb_i) begin
      case (cmd_op_i)
        OP_RESET:      clr_d  = 1'b1;
        OP_ARM:        arm_d  = 1'b1;
        OP_SET_COUNTS: cnt_ld = 1'b1;
        OP_SET_MASK0, OP_SET_MASK1, OP_SET_MASK2, OP_SET_MASK3: mask_d[stg_idx] = 1'b1;
        OP_SET_VAL0, OP_SET_VAL1, OP_SET_VAL2, OP_SET_VAL3:     val_d[stg_idx]  = 1'b1;
        OP_SET_CFG0, OP_SET_CFG1, OP_SET_CFG2, OP_SET_CFG3:     cfg_d[stg_idx]  = 1'b1;
        default: ; // unknown op is dropped
      endcase
    end
  end

  // data word only matters together with a strobe
  always_ff @(posedge clk_i) begin
    if (cmd_stb_i) data_q <= cmd_data_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      mask_q <= '0;
      val_q  <= '0;
      cfg_q  <= '0;
      clr_q  <= 1'b0;
      arm_q  <= 1'b0;
    end else begin
      mask_q <= mask_d;
      val_q  <= val_d;
      cfg_q  <= cfg_d;
      clr_q  <= clr_d;
      arm_q  <= arm_d;
    end
  end

  // counts survive the RESET opcode and clear on rst_in only
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      delay_q <= '0;
      read_q  <= '0;
    end else if (cnt_ld) begin
      delay_q <= cmd_data_i[CMD_W-1 -: CNT_W]; // upper half
      read_q  <= cmd_data_i[CNT_W-1:0];
    end
  end

  assign cfg.data     = data_q;
  assign cfg.set_mask = mask_q;
  assign cfg.set_val  = val_q;
  assign cfg.set_cfg  = cfg_q;
  assign cfg.arm      = arm_q;
  assign core_clr_o   = clr_q;
  assign arm_o        = arm_q;
  assign delay_cnt_o  = delay_q;
  assign read_cnt_o   = read_q;

  // one command per strobe, so never two stage strobes at once
  a_stb_onehot: assert property (@(posedge clk_i) disable iff (!rst_in)
    $onehot0({cfg.set_mask, cfg.set_val, cfg.set_cfg}));

endmodule : sump_cmd_dec

/* tb_la_core.sv */
// replays la_stim.txt one record at a time, inputs driven 1 unit after the rising edge
// outputs checked at the falling edge, readout words come from a small capture model
// non-strobed cycles carry LFSR filler, which the DUT must never store
module tb_la_core;
  import la_trig_pkg::*;

  localparam int PERIOD = 4;

  logic        clk_i;
  logic        rst_in;
  logic        cmd_stb_i;
  logic [7:0]  cmd_op_i;
  logic [31:0] cmd_data_i;
  logic        smpl_stb_i;
  smpl_t       smpls_i;
  logic        trig_o;
  logic        armed_o;
  logic        dout_vld_o;
  smpl_t       dout_o;

  string       lines[$];            // raw stim records
  int          n_lines   = 0;
  logic [31:0] lfsr_q    = 32'd44839;
  bit          exp_trig  = 1'b0;    // armed by a T record for one check
  smpl_t       hist[$];             // model: samples the ring holds, oldest first
  smpl_t       exp_q[$];            // words still due on dout_o
  smpl_t       ref_q[$];            // same words, for the R records
  bit          rec       = 1'b0;    // model: capture recording
  bit          in_post   = 1'b0;
  logic [15:0] post_left = '0;
  logic [15:0] delay_m   = '0;
  logic [15:0] read_m    = '0;

  la_core UUT (
    .clk_i      (clk_i),
    .rst_in     (rst_in),
    .cmd_stb_i  (cmd_stb_i),
    .cmd_op_i   (cmd_op_i),
    .cmd_data_i (cmd_data_i),
    .smpl_stb_i (smpl_stb_i),
    .smpls_i    (smpls_i),
    .trig_o     (trig_o),
    .armed_o    (armed_o),
    .dout_vld_o (dout_vld_o),
    .dout_o     (dout_o)
  );

  always #(PERIOD / 2) clk_i = ~clk_i;

  // fibonacci, taps 32 22 2 1, one step per bit taken
  function automatic smpl_t filler_word();
    smpl_t w;
    logic  fb;
    w = '0;
    for (int i = 0; i < CHLS; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      w      = {w[CHLS-2:0], fb};
    end
    return w;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_trig(input bit want, input bit got);
    if (want != got)
      fail_run($sformatf("MISMATCH at %0t: trig_o expected %0b got %0b", $time, want, got));
  endtask

  task automatic check_armed(input bit want, input bit got);
    if (want != got)
      fail_run($sformatf("MISMATCH at %0t: armed_o expected %0b got %0b", $time, want, got));
  endtask

  task automatic check_sample(input string what, input smpl_t want, input smpl_t got);
    if (want !== got)
      fail_run($sformatf("MISMATCH at %0t: %s expected %h got %h", $time, what, want, got));
  endtask

  // post count ran out, the newest read_m stored samples are due
  task automatic capture_done();
    smpl_t w;
    rec     = 1'b0;
    in_post = 1'b0;
    if (hist.size() < int'(read_m))
      fail_run("stim asks for more readout words than samples were stored");
    for (int i = 0; i < int'(read_m); i++) begin
      w = hist[hist.size() - 1 - i]; // newest first
      exp_q.push_back(w);
      ref_q.push_back(w);
    end
  endtask

  task automatic run_cycle(input bit cstb, input logic [7:0] op, input logic [31:0] data,
                           input bit sstb, input smpl_t smpl);
    @(posedge clk_i);
    #1;
    cmd_stb_i  = cstb;
    cmd_op_i   = op;
    cmd_data_i = data;
    smpl_stb_i = sstb;
    smpls_i    = smpl;
    @(negedge clk_i); // outputs settled from the last edge
    check_trig(exp_trig, trig_o);
    exp_trig = 1'b0;
    if (dout_vld_o) begin
      if (exp_q.size() == 0) fail_run("dout_vld_o high with no readout word due");
      else check_sample("dout_o", exp_q.pop_front(), dout_o);
    end
  endtask

  task automatic apply_record(input string line);
    byte         tag;
    logic [31:0] a;
    logic [31:0] b;
    a   = '0;
    b   = '0;
    tag = line.getc(0);
    if (line.len() > 1) void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
    case (tag)
      "C": begin
        run_cycle(1'b1, a[7:0], b, 1'b0, filler_word());
        case (a[7:0])
          8'h00: begin // core reset drops the whole capture
            rec     = 1'b0;
            in_post = 1'b0;
            hist.delete();
          end
          8'h01: rec = 1'b1;
          8'h81: begin
            delay_m = b[31:16];
            read_m  = (b[15:0] > 16'(DEPTH)) ? 16'(DEPTH) : b[15:0]; // ring size caps it
          end
          default: ;
        endcase
      end
      "S": begin
        run_cycle(1'b0, 8'h00, 32'h0, 1'b1, a);
        if (rec) hist.push_back(a);
        if (in_post) begin
          post_left = post_left - 16'd1;
          if (post_left == 16'd0) capture_done();
        end
      end
      "I": repeat (a) run_cycle(1'b0, 8'h00, 32'h0, 1'b0, filler_word());
      "T": begin
        exp_trig = 1'b1;
        if (rec && !in_post) begin // trigger only counts while recording
          if (delay_m == 16'd0) begin
            capture_done();
          end else begin
            in_post   = 1'b1;
            post_left = delay_m;
          end
        end
      end
      "R": begin
        if (ref_q.size() == 0) fail_run("R record with no readout word in the model");
        else check_sample("R record", ref_q.pop_front(), a);
      end
      "A": check_armed(a[0], armed_o);
      "#", 8'h0a, 8'h0d: ; // comment or blank
      default: fail_run($sformatf("unknown record in stim file: %s", line));
    endcase
  endtask

  initial begin
    int    fd;
    string line;
    clk_i      = 1'b0;
    rst_in     = 1'b0;
    cmd_stb_i  = 1'b0;
    cmd_op_i   = '0;
    cmd_data_i = '0;
    smpl_stb_i = 1'b0;
    smpls_i    = '0;
    fd = $fopen("la_stim.txt", "r");
    if (fd == 0) fail_run("could not open la_stim.txt");
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0) lines.push_back(line);
    end
    $fclose(fd);
    if (lines.size() == 0) fail_run("stim file holds no records");
    n_lines = lines.size();
    repeat (2) @(posedge clk_i);
    #1 rst_in = 1'b1;
    foreach (lines[i]) apply_record(lines[i]);
    if (exp_q.size() != 0 || ref_q.size() != 0) begin
      fail_run("run ended with readout words never seen or never listed");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

  // watchdog, 20 cycles per record plus slack
  initial begin
    wait (n_lines != 0);
    #((n_lines * 20 + 200) * PERIOD);
    fail_run("timeout: the stimulus did not finish in time");
  end

endmodule : tb_la_core

/* trig_cfg_if.sv */
// decoded configuration from the command decoder to all trigger stages
// strobes are one cycle wide and one-hot over the stages
interface trig_cfg_if;
  import la_cmd_pkg::*;
  import la_trig_pkg::*;

  logic [CMD_W-1:0] data;     // registered command word
  logic [N_STG-1:0] set_mask; // bit per stage
  logic [N_STG-1:0] set_val;
  logic [N_STG-1:0] set_cfg;
  logic             arm;      // common to all stages

  modport dec (
    output data,
    output set_mask,
    output set_val,
    output set_cfg,
    output arm
  );

  modport stg (
    input data,
    input set_mask,
    input set_val,
    input set_cfg,
    input arm
  );

endinterface : trig_cfg_if

/* trig_stage.sv */
// one level-0 trigger stage, parallel or serial compare, no delay and no chaining
// serial history includes the sample being strobed, newest bit in bit 0
module trig_stage #(
  parameter int STG = 0 // stage number, picks its strobe bits
) (
  input  logic               clk_i,
  input  logic               rst_in,
  input  logic               clr_i,      // core reset from the RESET opcode
  trig_cfg_if.stg            cfg,
  input  logic               smpl_stb_i,
  input  la_trig_pkg::smpl_t smpls_i,
  output logic               run_o       // combinational, only when active
);
  import la_trig_pkg::*;

  smpl_t            mask_q, val_q;
  logic             ser_q, act_q;
  logic [CHL_W-1:0] chl_q;
  smpl_t            shft_q, shft_d;
  smpl_t            cmp_vec;
  logic             hit;
  logic             run;
  stg_state_e       state_q, state_d;

  assign shft_d  = {shft_q[CHLS-2:0], smpls_i[chl_q]}; // shift in selected channel
  assign cmp_vec = ser_q ? shft_d : smpls_i;
  assign hit     = ((cmp_vec ^ val_q) & mask_q) == '0; // masked bits all equal

  always_comb begin
    state_d = state_q;
    run     = 1'b0;
    case (state_q)
      IDLE:  if (cfg.arm) state_d = ARMD;
      ARMD:  if (smpl_stb_i && hit) state_d = MTCHD; // compare only on strobes
      MTCHD: begin
        if (smpl_stb_i) begin // next sample fires the stage
          run     = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  assign run_o = run & act_q; // inactive stages match silently

  always_ff @(posedge clk_i) begin
    if (!rst_in || clr_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // history runs on every strobe, armed or not
  always_ff @(posedge clk_i) begin
    if (!rst_in || clr_i) begin
      shft_q <= '0;
    end else if (smpl_stb_i) begin
      shft_q <= shft_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in || clr_i) begin
      mask_q <= '0;
      val_q  <= '0;
      ser_q  <= 1'b0;
      act_q  <= 1'b0;
      chl_q  <= '0;
    end else begin
      if (cfg.set_mask[STG]) mask_q <= cfg.data[CHLS-1:0];
      if (cfg.set_val[STG])  val_q  <= cfg.data[CHLS-1:0];
      if (cfg.set_cfg[STG]) begin
        act_q <= cfg.data[CFG_ACT];
        ser_q <= cfg.data[CFG_SER];
        chl_q <= {cfg.data[CFG_CHL_B4], cfg.data[CFG_CHL_HI:CFG_CHL_LO]};
      end
    end
  end

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_in)
    state_q inside {IDLE, ARMD, MTCHD});

  // a run pulse needs a sample and a stage that matched on an earlier strobe
  a_run_stb: assert property (@(posedge clk_i) disable iff (!rst_in)
    run_o |-> smpl_stb_i && state_q == MTCHD);

endmodule : trig_stage
